//--- rtl/mmio_settings.svh
// Register indexes, field widths, identity constants and system register count
`ifndef MMIO_SETTINGS_SVH
`define MMIO_SETTINGS_SVH

// MMIO address in 4-byte units, transaction id and data word widths
`define MMIO_ADDR_W 8
`define MMIO_TID_W 9
`define MMIO_DATA_W 64

// The system register file is small, so a 4-bit index reaches all of it
`define SREG_COUNT 16
`define SREG_IDX_W 4

// Local register indexes count 8-byte words, which is the MMIO address halved
`define CSR_IDX_DFH 3'd0
`define CSR_IDX_ID_L 3'd1
`define CSR_IDX_ID_H 3'd2
`define CSR_IDX_RSVD0 3'd3
`define CSR_IDX_RSVD1 3'd4
`define CSR_IDX_SREG_ADDR 3'd5
`define CSR_IDX_SREG_DATA 3'd6

// Addresses above this one belong to nobody and get no answer
`define CSR_ADDR_MAX 8'd13

// Function id and feature header, type AFU in the top nibble with revision 1
`define AFU_ID 128'h5e3a9c41_7b20_4d8f_a613_2c9e0b7f4d58
`define AFU_DFH 64'h1000_0000_0000_1001

`endif

//--- rtl/mmio_pkg.sv
// Package with the MMIO vector types and the arbiter state enum
`include "mmio_settings.svh"

package mmio_pkg;

    // MMIO address, counted in 4-byte units
    typedef logic [`MMIO_ADDR_W-1:0] t_mmio_addr;

    // Transaction id that pairs a read with its response
    typedef logic [`MMIO_TID_W-1:0] t_mmio_tid;

    // One data word as carried on the request and response channels
    typedef logic [`MMIO_DATA_W-1:0] t_mmio_data;

    // Local register index after the address range has been checked
    typedef logic [2:0] t_csr_idx;

    // Index into the system register file
    typedef logic [`SREG_IDX_W-1:0] t_sreg_idx;

    // The arbiter is either free or waiting one cycle for read data
    typedef enum logic
    {
        arb_idle,
        arb_read_wait
    } t_arb_state;

endpackage

//--- rtl/mmio_if.sv
// MMIO request interface and system register port interface with their modports
`timescale 1ns/10ps

// One MMIO request, valid for a single cycle with no acknowledgment
interface mmio_req_if
    import mmio_pkg::*;
;
    logic valid;
    logic write;
    t_mmio_addr addr;
    t_mmio_tid tid;
    t_mmio_data data;

    // Both the read responder and the write handler only watch the requests
    modport target
    (
        input valid,
        input write,
        input addr,
        input tid,
        input data
    );

endinterface

// One client's path to the shared system register memory
interface sreg_port_if
    import mmio_pkg::*;
;
    logic req;
    logic we;
    t_sreg_idx addr;
    t_mmio_data wdata;
    logic gnt;
    logic rvalid;
    t_mmio_data rdata;

    // The client holds req and its fields until the cycle in which gnt is high
    modport client
    (
        output req,
        output we,
        output addr,
        output wdata,
        input gnt,
        input rvalid,
        input rdata
    );

    // rvalid comes back exactly one cycle after a granted read
    modport arbiter
    (
        input req,
        input we,
        input addr,
        input wdata,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

//--- rtl/csr_rd_responder.sv
// MMIO read decoder with direct identity answers and the held system register response
`timescale 1ns/10ps
`include "mmio_settings.svh"

module csr_rd_responder
    import mmio_pkg::*;
(
    input logic clk,
    input logic reset_n,
    mmio_req_if.target req,
    input t_sreg_idx sreg_addr,
    sreg_port_if.client rd_port,
    output logic rsp_valid,
    output t_mmio_tid rsp_tid,
    output t_mmio_data rsp_data
);

    logic [127:0] afu_id;
    t_csr_idx csr_idx;
    logic is_read;
    logic direct_rd;
    logic sreg_rd_start;
    logic hold_emit;
    logic rd_req_q;
    t_sreg_idx rd_addr_q;
    t_mmio_tid sreg_tid_q;
    logic hold_valid_q;
    t_mmio_data hold_data_q;

    // The id constant is sliced into halves below, so give it a name first
    assign afu_id = `AFU_ID;

    // Odd addresses drop their low bit and alias the even address below them
    assign csr_idx = req.addr[3:1];
    assign is_read = req.valid && !req.write && (req.addr <= `CSR_ADDR_MAX);

    // Every index but the data window is answered in the request cycle
    assign direct_rd = is_read && (csr_idx != `CSR_IDX_SREG_DATA);
    assign sreg_rd_start = is_read && (csr_idx == `CSR_IDX_SREG_DATA);

    // A held response only goes out when no direct read owns the channel
    assign hold_emit = hold_valid_q && !direct_rd;

    always_comb
    begin
        rsp_valid = 1'b0;
        rsp_tid = req.tid;
        rsp_data = '0;

        if (direct_rd)
        begin
            rsp_valid = 1'b1;
            case (csr_idx)
                `CSR_IDX_DFH: rsp_data = `AFU_DFH;
                `CSR_IDX_ID_L: rsp_data = afu_id[63:0];
                `CSR_IDX_ID_H: rsp_data = afu_id[127:64];
                `CSR_IDX_RSVD0, `CSR_IDX_RSVD1: rsp_data = '0;
                `CSR_IDX_SREG_ADDR: rsp_data = t_mmio_data'(sreg_addr);
                default: rsp_data = '0;
            endcase
        end
        else if (hold_valid_q)
        begin
            // The fetched word goes back with the tid of the read that asked for it
            rsp_valid = 1'b1;
            rsp_tid = sreg_tid_q;
            rsp_data = hold_data_q;
        end
    end

    // The fetch request rises the cycle after the read and drops on its grant
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_req_q <= 1'b0;
        end
        else if (sreg_rd_start)
        begin
            rd_req_q <= 1'b1;
        end
        else if (rd_port.gnt)
        begin
            rd_req_q <= 1'b0;
        end
    end

    // Latch the index and tid at launch so a later address write can't disturb them
    always_ff @(posedge clk)
    begin
        if (sreg_rd_start)
        begin
            rd_addr_q <= sreg_addr;
            sreg_tid_q <= req.tid;
        end
    end

    // Only one fetch is outstanding, so rvalid never meets a full hold register
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            hold_valid_q <= 1'b0;
        end
        else if (rd_port.rvalid)
        begin
            hold_valid_q <= 1'b1;
        end
        else if (hold_emit)
        begin
            hold_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_port.rvalid)
        begin
            hold_data_q <= rd_port.rdata;
        end
    end

    // This client only ever reads
    assign rd_port.req = rd_req_q;
    assign rd_port.we = 1'b0;
    assign rd_port.addr = rd_addr_q;
    assign rd_port.wdata = '0;

endmodule

//--- rtl/csr_wr_handler.sv
// MMIO write decoder with the system register address and the data window writer
`timescale 1ns/10ps
`include "mmio_settings.svh"

module csr_wr_handler
    import mmio_pkg::*;
(
    input logic clk,
    input logic reset_n,
    mmio_req_if.target req,
    output t_sreg_idx sreg_addr,
    sreg_port_if.client wr_port
);

    t_csr_idx csr_idx;
    logic is_write;
    logic wr_req_q;
    t_sreg_idx wr_addr_q;
    t_mmio_data wr_data_q;

    // Same decode as the read side; writes to any other index fall on the floor
    assign csr_idx = req.addr[3:1];
    assign is_write = req.valid && req.write && (req.addr <= `CSR_ADDR_MAX);

    // The address register selects the entry behind the data window
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            sreg_addr <= '0;
        end
        else if (is_write && (csr_idx == `CSR_IDX_SREG_ADDR))
        begin
            sreg_addr <= req.data[`SREG_IDX_W-1:0];
        end
    end

    // A new window write takes precedence over clearing on the grant of the last one
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_req_q <= 1'b0;
        end
        else if (is_write && (csr_idx == `CSR_IDX_SREG_DATA))
        begin
            wr_req_q <= 1'b1;
        end
        else if (wr_port.gnt)
        begin
            wr_req_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (is_write && (csr_idx == `CSR_IDX_SREG_DATA))
        begin
            wr_addr_q <= sreg_addr;
            wr_data_q <= req.data;
        end
    end

    assign wr_port.req = wr_req_q;
    assign wr_port.we = 1'b1;
    assign wr_port.addr = wr_addr_q;
    assign wr_port.wdata = wr_data_q;

endmodule

//--- rtl/sreg_arbiter.sv
// Fixed priority arbiter for the single system register memory port
`timescale 1ns/10ps

module sreg_arbiter
    import mmio_pkg::*;
(
    input logic clk,
    input logic reset_n,
    sreg_port_if.arbiter wr_port,
    sreg_port_if.arbiter rd_port,
    output logic mem_en,
    output logic mem_we,
    output t_sreg_idx mem_addr,
    output t_mmio_data mem_wdata,
    input t_mmio_data mem_rdata
);

    t_arb_state state;
    logic wr_gnt;
    logic rd_gnt;
    logic owner_wr_q;

    // Nothing is granted while read data is still on its way back
    assign wr_gnt = (state == arb_idle) && wr_port.req;
    assign rd_gnt = (state == arb_idle) && rd_port.req && !wr_port.req;

    assign wr_port.gnt = wr_gnt;
    assign rd_port.gnt = rd_gnt;

    // The granted client owns the memory port for this cycle
    assign mem_en = wr_gnt || rd_gnt;
    assign mem_we = wr_gnt ? wr_port.we : rd_port.we;
    assign mem_addr = wr_gnt ? wr_port.addr : rd_port.addr;
    assign mem_wdata = wr_gnt ? wr_port.wdata : rd_port.wdata;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= arb_idle;
            owner_wr_q <= 1'b0;
        end
        else
        begin
            case (state)
                arb_idle:
                begin
                    if (mem_en && !mem_we)
                    begin
                        state <= arb_read_wait;
                        owner_wr_q <= wr_gnt;
                    end
                end
                default:
                begin
                    state <= arb_idle;
                end
            endcase
        end
    end

    // Registered memory data is valid the cycle after the read grant
    assign wr_port.rvalid = (state == arb_read_wait) && owner_wr_q;
    assign rd_port.rvalid = (state == arb_read_wait) && !owner_wr_q;
    assign wr_port.rdata = mem_rdata;
    assign rd_port.rdata = mem_rdata;

endmodule

//--- rtl/sreg_mem.sv
// Single-port system register storage with registered read data
`timescale 1ns/10ps
`include "mmio_settings.svh"

module sreg_mem
    import mmio_pkg::*;
(
    input logic clk,
    input logic mem_en,
    input logic mem_we,
    input t_sreg_idx mem_addr,
    input t_mmio_data mem_wdata,
    output t_mmio_data mem_rdata
);

    t_mmio_data regs [`SREG_COUNT];

    // A write leaves the read data register untouched, so a prior read stays visible
    always_ff @(posedge clk)
    begin
        if (mem_en)
        begin
            if (mem_we)
            begin
                regs[mem_addr] <= mem_wdata;
            end
            else
            begin
                mem_rdata <= regs[mem_addr];
            end
        end
    end

endmodule

//--- rtl/mmio_csr_top.sv
// Top level of the MMIO register block joining decoders, arbiter and memory
`timescale 1ns/10ps

module mmio_csr_top
    import mmio_pkg::*;
(
    input logic clk,
    input logic reset_n,
    input logic req_valid,
    input logic req_write,
    input t_mmio_addr req_addr,
    input t_mmio_tid req_tid,
    input t_mmio_data req_data,
    output logic rsp_valid,
    output t_mmio_tid rsp_tid,
    output t_mmio_data rsp_data
);

    t_sreg_idx sreg_addr;
    logic mem_en;
    logic mem_we;
    t_sreg_idx mem_addr;
    t_mmio_data mem_wdata;
    t_mmio_data mem_rdata;

    mmio_req_if req_bus();
    sreg_port_if wr_port();
    sreg_port_if rd_port();

    // Host requests fan out to both decoders through one bundle
    assign req_bus.valid = req_valid;
    assign req_bus.write = req_write;
    assign req_bus.addr = req_addr;
    assign req_bus.tid = req_tid;
    assign req_bus.data = req_data;

    csr_rd_responder csr_rd_responder_inst
    (
        .clk(clk),
        .reset_n(reset_n),
        .req(req_bus.target),
        .sreg_addr(sreg_addr),
        .rd_port(rd_port.client),
        .rsp_valid(rsp_valid),
        .rsp_tid(rsp_tid),
        .rsp_data(rsp_data)
    );

    csr_wr_handler csr_wr_handler_inst
    (
        .clk(clk),
        .reset_n(reset_n),
        .req(req_bus.target),
        .sreg_addr(sreg_addr),
        .wr_port(wr_port.client)
    );

    sreg_arbiter sreg_arbiter_inst
    (
        .clk(clk),
        .reset_n(reset_n),
        .wr_port(wr_port.arbiter),
        .rd_port(rd_port.arbiter),
        .mem_en(mem_en),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata)
    );

    sreg_mem sreg_mem_inst
    (
        .clk(clk),
        .mem_en(mem_en),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata)
    );

endmodule

//--- bench/mmio_csr_checker.sv
// Reference model and response checker for the MMIO register block
`timescale 1ns/10ps
`include "mmio_settings.svh"

module mmio_csr_checker
    import mmio_pkg::*;
(
    input logic clk,
    input logic reset_n,
    input logic req_valid,
    input logic req_write,
    input t_mmio_addr req_addr,
    input t_mmio_tid req_tid,
    input t_mmio_data req_data,
    input logic rsp_valid,
    input t_mmio_tid rsp_tid,
    input t_mmio_data rsp_data,
    input logic [159:0] test_name,
    input logic finish_check,
    output int error_count,
    output int pending_count
);

    logic [127:0] afu_id;
    t_csr_idx idx;
    logic in_range;
    logic is_direct;
    logic is_sreg_read;
    t_sreg_idx model_sreg_addr;
    t_mmio_data shadow [`SREG_COUNT];

    // Outstanding system register reads with one entry per tid
    t_mmio_tid pend_tid [$];
    t_mmio_data pend_data [$];
    logic [159:0] pend_name [$];

    int errors = 0;
    int checked = 0;
    logic reported = 1'b0;

    assign afu_id = `AFU_ID;
    assign error_count = errors;
    assign pending_count = pend_tid.size();

    // The register index is the address in 4-byte units halved
    assign idx = t_csr_idx'(req_addr >> 1);
    assign in_range = req_valid && (req_addr <= `CSR_ADDR_MAX);
    assign is_direct = in_range && !req_write && (idx != `CSR_IDX_SREG_DATA);
    assign is_sreg_read = in_range && !req_write && (idx == `CSR_IDX_SREG_DATA);

    // Expected answer of a register that responds in the request cycle
    function automatic t_mmio_data direct_value(input t_csr_idx i);
        case (i)
            3'd0: return `AFU_DFH;
            3'd1: return afu_id[63:0];
            3'd2: return afu_id[127:64];
            3'd5: return t_mmio_data'(model_sreg_addr);
            default: return '0;
        endcase
    endfunction

    task automatic compare_field(input logic [159:0] name, input string field,
                                 input t_mmio_data expected, input t_mmio_data actual);
        if (expected !== actual)
        begin
            $display("Mismatch in %0s: %0s expected %h, actual %h", name, field,
                     expected, actual);
            errors++;
        end
    endtask

    // Pair a late response with the read that launched it
    task automatic match_held_response();
        int found;
        found = -1;
        foreach (pend_tid[i])
        begin
            if (found < 0 && pend_tid[i] == rsp_tid)
            begin
                found = i;
            end
        end
        if (found < 0)
        begin
            $display("Response with tid %h matches no outstanding read, data %h",
                     rsp_tid, rsp_data);
            errors++;
        end
        else
        begin
            compare_field(pend_name[found], "sreg data", pend_data[found], rsp_data);
            checked++;
            pend_tid.delete(found);
            pend_data.delete(found);
            pend_name.delete(found);
        end
    endtask

    // Outputs are sampled on the rising edge half a cycle after the inputs moved
    always @(posedge clk)
    begin
        if (!reset_n)
        begin
            model_sreg_addr = '0;
            pend_tid.delete();
            pend_data.delete();
            pend_name.delete();
        end
        else
        begin
            if (is_direct)
            begin
                if (!rsp_valid)
                begin
                    $display("Direct read in %0s at address %0d got no response",
                             test_name, req_addr);
                    errors++;
                end
                else
                begin
                    compare_field(test_name, "tid", t_mmio_data'(req_tid),
                                  t_mmio_data'(rsp_tid));
                    compare_field(test_name, "data", direct_value(idx), rsp_data);
                    checked++;
                end
            end
            else if (rsp_valid)
            begin
                match_held_response();
            end

            // The word expected back is whatever the window holds right now
            if (is_sreg_read)
            begin
                pend_tid.push_back(req_tid);
                pend_data.push_back(shadow[model_sreg_addr]);
                pend_name.push_back(test_name);
            end

            // Only the address register and the data window take writes
            if (in_range && req_write && idx == `CSR_IDX_SREG_ADDR)
            begin
                model_sreg_addr = req_data[`SREG_IDX_W-1:0];
            end
            if (in_range && req_write && idx == `CSR_IDX_SREG_DATA)
            begin
                shadow[model_sreg_addr] = req_data;
            end

            if (finish_check && !reported)
            begin
                $display("Checker summary: %0d responses checked, %0d errors",
                         checked, errors);
                reported = 1'b1;
            end
        end
    end

endmodule

//--- bench/mmio_csr_tb.sv
// Testbench top with clock, reset, stimulus table, timeout, DUT and checker
`timescale 1ns/10ps

module mmio_csr_tb
    import mmio_pkg::*;
;
    localparam int MAX_STEPS = 64;

    logic clk = 1'b0;
    logic reset_n;
    logic req_valid;
    logic req_write;
    t_mmio_addr req_addr;
    t_mmio_tid req_tid;
    t_mmio_data req_data;
    logic rsp_valid;
    t_mmio_tid rsp_tid;
    t_mmio_data rsp_data;
    logic [159:0] test_name;
    logic finish_check;
    int error_count;
    int pending_count;

    // Stimulus table with one request per entry followed by its idle cycles
    logic [159:0] step_name [MAX_STEPS];
    logic step_write [MAX_STEPS];
    t_mmio_addr step_addr [MAX_STEPS];
    t_mmio_tid step_tid [MAX_STEPS];
    t_mmio_data step_data [MAX_STEPS];
    int step_gap [MAX_STEPS];
    int step_count = 0;
    int gap_total = 0;

    int cycle_count = 0;
    int timeout_limit = 100000;

    always #5 clk = ~clk;

    mmio_csr_top mmio_csr_top_inst
    (
        .clk(clk),
        .reset_n(reset_n),
        .req_valid(req_valid),
        .req_write(req_write),
        .req_addr(req_addr),
        .req_tid(req_tid),
        .req_data(req_data),
        .rsp_valid(rsp_valid),
        .rsp_tid(rsp_tid),
        .rsp_data(rsp_data)
    );

    mmio_csr_checker checker_inst
    (
        .clk(clk),
        .reset_n(reset_n),
        .req_valid(req_valid),
        .req_write(req_write),
        .req_addr(req_addr),
        .req_tid(req_tid),
        .req_data(req_data),
        .rsp_valid(rsp_valid),
        .rsp_tid(rsp_tid),
        .rsp_data(rsp_data),
        .test_name(test_name),
        .finish_check(finish_check),
        .error_count(error_count),
        .pending_count(pending_count)
    );

    function automatic t_mmio_data random_word();
        return {$urandom, $urandom};
    endfunction

    // Every entry gets its own tid
    task automatic add_step(input logic [159:0] name, input logic write,
                            input t_mmio_addr addr, input t_mmio_data data, input int gap);
        step_name[step_count] = name;
        step_write[step_count] = write;
        step_addr[step_count] = addr;
        step_tid[step_count] = t_mmio_tid'(step_count * 5 + 1);
        step_data[step_count] = data;
        step_gap[step_count] = gap;
        gap_total += gap;
        step_count++;
    endtask

    task automatic build_table();
        t_mmio_data sel [3];
        sel = '{64'd3, 64'd9, 64'd14};

        // Identity registers where odd addresses read the even one below
        add_step("id_dfh", 1'b0, 8'd0, '0, 0);
        add_step("id_dfh_odd", 1'b0, 8'd1, '0, 0);
        add_step("id_low", 1'b0, 8'd2, '0, 0);
        add_step("id_high", 1'b0, 8'd4, '0, 0);
        add_step("id_high_odd", 1'b0, 8'd5, '0, 0);
        add_step("rsvd_0", 1'b0, 8'd6, '0, 0);
        add_step("rsvd_0_odd", 1'b0, 8'd7, '0, 0);
        add_step("rsvd_1", 1'b0, 8'd8, '0, 0);
        add_step("rsvd_1_odd", 1'b0, 8'd9, '0, 1);

        // Address register write and read back
        add_step("addr_write", 1'b1, 8'd10, 64'd3, 0);
        add_step("addr_read", 1'b0, 8'd10, '0, 0);
        add_step("addr_read_odd", 1'b0, 8'd11, '0, 1);

        // Fill three system registers, then read each one back
        foreach (sel[i])
        begin
            add_step("rt_select", 1'b1, 8'd10, sel[i], 0);
            add_step("rt_write", 1'b1, 8'd12 + t_mmio_addr'(i % 2), random_word(), 0);
        end
        foreach (sel[i])
        begin
            add_step("rt_select", 1'b1, 8'd10, sel[i], 0);
            add_step("rt_read", 1'b0, 8'd12 + t_mmio_addr'(i % 2), '0, 6);
        end

        // Direct reads land while the fetched word is ready and in the hold register
        add_step("race_sreg_read", 1'b0, 8'd12, '0, 1);
        add_step("race_dfh", 1'b0, 8'd0, '0, 0);
        add_step("race_id_low", 1'b0, 8'd2, '0, 0);
        add_step("race_id_high", 1'b0, 8'd4, '0, 6);

        // The write reaches the memory first, so the read sees the new word
        add_step("wr_rd_write", 1'b1, 8'd12, random_word(), 0);
        add_step("wr_rd_read", 1'b0, 8'd12, '0, 6);

        // Out of range reads are silent, and these writes change nothing
        add_step("oob_read", 1'b0, 8'd14, '0, 0);
        add_step("oob_read_alias", 1'b0, 8'd28, '0, 0);
        add_step("oob_read_top", 1'b0, 8'd255, '0, 6);
        add_step("unused_wr_dfh", 1'b1, 8'd0, random_word(), 0);
        add_step("unused_wr_id", 1'b1, 8'd2, random_word(), 0);
        add_step("unused_wr_rsvd", 1'b1, 8'd8, random_word(), 0);
        add_step("oob_wr_addr", 1'b1, 8'd26, 64'd5, 0);
        add_step("oob_wr_data", 1'b1, 8'd28, random_word(), 0);
        add_step("unused_dfh", 1'b0, 8'd0, '0, 0);
        add_step("unused_id_low", 1'b0, 8'd2, '0, 0);
        add_step("unused_addr", 1'b0, 8'd10, '0, 0);
        add_step("unused_sreg", 1'b0, 8'd12, '0, 6);
    endtask

    // Runaway guard sized from the table once it is built
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit)
        begin
            $display("Timeout after %0d cycles, system register responses never arrived",
                     cycle_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(20496));
        reset_n = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_tid = '0;
        req_data = '0;
        test_name = "reset";
        finish_check = 1'b0;

        build_table();
        timeout_limit = gap_total + step_count + 4 + 50;

        repeat (4) @(negedge clk);
        reset_n = 1'b1;

        // Requests change on the falling edge and the checker samples on the rising one
        for (int i = 0; i < step_count; i++)
        begin
            @(negedge clk);
            test_name = step_name[i];
            req_valid = 1'b1;
            req_write = step_write[i];
            req_addr = step_addr[i];
            req_tid = step_tid[i];
            req_data = step_data[i];
            repeat (step_gap[i])
            begin
                @(negedge clk);
                req_valid = 1'b0;
            end
        end
        @(negedge clk);
        req_valid = 1'b0;

        // Any stray response in the drain cycles is caught by the checker
        wait (pending_count == 0);
        repeat (4) @(negedge clk);
        finish_check = 1'b1;
        @(posedge clk);
        #1;

        if (error_count == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+rtl
rtl/mmio_pkg.sv
rtl/mmio_if.sv
rtl/csr_rd_responder.sv
rtl/csr_wr_handler.sv
rtl/sreg_arbiter.sv
rtl/sreg_mem.sv
rtl/mmio_csr_top.sv
bench/mmio_csr_checker.sv
bench/mmio_csr_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the MMIO register block testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -j 0 --top-module mmio_csr_tb -f src.f -o mmio_csr_sim \
    && ./obj_dir/mmio_csr_sim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log

# Only the exact pass line counts as success
grep -qx "TESTS PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
